// ==== files.f ====
hw/map_geometry_pkg.sv
hw/player_pkg.sv
hw/player_if.sv
hw/player_motion.sv
hw/contact_detect.sv
hw/terrain_addr.sv
hw/sprite_addr.sv
hw/game_map_top.sv
testbench/game_map_chk.sv
testbench/game_map_tb.sv

// ==== hw/contact_detect.sv ====
`timescale 1ns/1ns
`default_nettype none

module contact_detect (
    input  logic        clk,
    input  logic        rst,
    player_if.observer  pl,
    output logic        p1_collision,
    output logic        p1_land,
    output logic        should_down,
    output logic [15:0] led
);

    map_geometry_pkg::coord_t dh;
    map_geometry_pkg::coord_t dv;
    logic                     is_right;
    logic                     is_left;
    logic                     rising;
    logic                     falling;

    assign dh      = pl.disp_h;
    assign dv      = pl.disp_v;
    assign is_right = (pl.state == player_pkg::RIGHT);
    assign is_left  = (pl.state == player_pkg::LEFT);
    assign rising   = (pl.jump == player_pkg::RISE);
    assign falling  = (pl.jump == player_pkg::FALL);

    // head on the underside of wall 1, or walking into wall 7
    assign p1_collision = (rising && dv == 10'd9 && dh < 10'd230)
                        || (is_right && dh >= 10'd247 && dv <= 10'd10);

    // feet reach a surface while falling
    assign p1_land = falling && ((dv == 10'd0 && dh < 10'd248)              // floor
                              || (dv == 10'd20 && dh >= 10'd261
                                  && dh <= 10'd292)                          // wall 7 top
                              || (dv == 10'd48 && dh < 10'd230));           // wall 1 top

    // walked off an edge
    assign should_down = (is_left && dh <= 10'd255 && (dv == 10'd19 || dv == 10'd20))
                       || (is_right && dh >= 10'd228 && (dv == 10'd47 || dv == 10'd48));

    // status pattern, collision highest
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            led <= 16'h000F;
        else if (p1_collision)
            led <= 16'hFFFF;
        else if (p1_land)
            led <= 16'h3FFF;
        else if (should_down)
            led <= 16'h0FFF;
        else
            led <= 16'h000F;  // idle
    end

endmodule

`default_nettype wire

// ==== hw/game_map_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_map_top #(
    parameter int STEP_H = player_pkg::STEP_H_DEFAULT,  // cycles per horizontal step, minus one
    parameter int STEP_V = player_pkg::STEP_V_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst,
    input  map_geometry_pkg::coord_t      vga_h,
    input  map_geometry_pkg::coord_t      vga_v,
    input  player_pkg::player_state_e     player_state,
    input  player_pkg::jump_e             player_jump,
    output map_geometry_pkg::sheet_addr_t addr,
    output logic [15:0]                   led,
    output logic                          p1_collision,
    output logic                          p1_land,
    output logic                          should_down
);

    logic                          t_hit;
    map_geometry_pkg::sheet_addr_t t_addr;

    player_if pl ();

    assign pl.state = player_state;  // pose and jump phase come from outside
    assign pl.jump  = player_jump;

    player_motion #(
        .STEP_H (STEP_H),
        .STEP_V (STEP_V)
    ) u_motion (
        .clk     (clk),
        .rst     (rst),
        .blocked (p1_collision),
        .pl      (pl.motion)
    );

    contact_detect u_contact (
        .clk          (clk),
        .rst          (rst),
        .pl           (pl.observer),
        .p1_collision (p1_collision),
        .p1_land      (p1_land),
        .should_down  (should_down),
        .led          (led)
    );

    terrain_addr u_terrain (
        .vga_h  (vga_h),
        .vga_v  (vga_v),
        .hit    (t_hit),
        .t_addr (t_addr)
    );

    sprite_addr u_sprite (
        .vga_h  (vga_h),
        .vga_v  (vga_v),
        .pl     (pl.observer),
        .t_hit  (t_hit),
        .t_addr (t_addr),
        .addr   (addr)
    );

endmodule

`default_nettype wire

// ==== hw/map_geometry_pkg.sv ====
`default_nettype none

package map_geometry_pkg;

    typedef logic [9:0]  coord_t;       // vga scan or map pixel coordinate
    typedef logic [16:0] sheet_addr_t;  // sprite-sheet rom address

    localparam coord_t      MAP_W   = 10'd320;   // also the sheet row pitch
    localparam coord_t      MAP_H   = 10'd240;
    localparam sheet_addr_t BG_ADDR = 17'd12900; // plain background texel

    // terrain pieces, earlier entries win on overlap
    typedef enum logic [3:0] {
        T_CEILING,
        T_RED_RIVER,
        T_BLUE_RIVER,
        T_GREEN_RIVER,
        T_FLOOR,
        T_LEFT_BOUND,
        T_RIGHT_BOUND,
        T_WALL_1,
        T_WALL_2,
        T_WALL_3,
        T_WALL_4,
        T_WALL_6,
        T_RED_DOOR,
        T_BLUE_DOOR,
        T_WALL_7
    } terrain_id_e;

    localparam int TERRAIN_COUNT = int'(T_WALL_7) + 1;

    typedef struct packed {
        coord_t org_h;    // map origin
        coord_t org_v;
        coord_t width;
        coord_t height;
        coord_t sheet_h;  // matching corner on the sheet
        coord_t sheet_v;
        logic   solid;    // single colour, sheet_h + sheet_v * MAP_W is the texel
    } terrain_rect_t;

    // field order: org_h, org_v, width, height, sheet_h, sheet_v, solid
    localparam terrain_rect_t TERRAIN_TABLE [0:TERRAIN_COUNT-1] = '{
        T_CEILING:     '{10'd0,   10'd0,   10'd320, 10'd10,  10'd0,   10'd220, 1'b0},
        T_RED_RIVER:   '{10'd160, 10'd230, 10'd20,  10'd6,   10'd1,   10'd61,  1'b1},
        T_BLUE_RIVER:  '{10'd220, 10'd230, 10'd20,  10'd6,   10'd70,  10'd70,  1'b1},
        T_GREEN_RIVER: '{10'd190, 10'd182, 10'd40,  10'd6,   10'd165, 10'd1,   1'b0},
        T_FLOOR:       '{10'd0,   10'd230, 10'd320, 10'd10,  10'd0,   10'd220, 1'b0},
        T_LEFT_BOUND:  '{10'd0,   10'd10,  10'd10,  10'd220, 10'd305, 10'd10,  1'b0},
        T_RIGHT_BOUND: '{10'd310, 10'd10,  10'd10,  10'd220, 10'd305, 10'd10,  1'b0},
        T_WALL_1:      '{10'd10,  10'd182, 10'd230, 10'd8,   10'd50,  10'd215, 1'b0},
        T_WALL_2:      '{10'd50,  10'd139, 10'd260, 10'd8,   10'd0,   10'd220, 1'b0},
        T_WALL_3:      '{10'd60,  10'd96,  10'd210, 10'd8,   10'd0,   10'd220, 1'b0},
        T_WALL_4:      '{10'd160, 10'd89,  10'd50,  10'd7,   10'd0,   10'd220, 1'b0},
        T_WALL_6:      '{10'd110, 10'd48,  10'd200, 10'd8,   10'd0,   10'd220, 1'b0},
        T_RED_DOOR:    '{10'd250, 10'd19,  10'd23,  10'd29,  10'd0,   10'd89,  1'b0},
        T_BLUE_DOOR:   '{10'd280, 10'd19,  10'd21,  10'd29,  10'd32,  10'd89,  1'b0},
        T_WALL_7:      '{10'd275, 10'd210, 10'd35,  10'd20,  10'd305, 10'd212, 1'b0}
    };

endpackage

`default_nettype wire

// ==== hw/player_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// player position and pose shared between motion, contact and sprite logic
interface player_if;

    map_geometry_pkg::coord_t  disp_h;  // rightward offset from spawn
    map_geometry_pkg::coord_t  disp_v;  // upward offset from the floor
    player_pkg::player_state_e state;   // from the top-level input
    player_pkg::jump_e         jump;

    // motion owns the displacements
    modport motion (output disp_h, output disp_v, input state, input jump);

    modport observer (input disp_h, input disp_v, input state, input jump);

endinterface

`default_nettype wire

// ==== hw/player_motion.sv ====
`timescale 1ns/1ns
`default_nettype none

module player_motion #(
    parameter int STEP_H = player_pkg::STEP_H_DEFAULT,
    parameter int STEP_V = player_pkg::STEP_V_DEFAULT
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     blocked,  // p1_collision, stops right moves
    player_if.motion pl
);

    localparam player_pkg::step_cnt_t STEP_H_C = player_pkg::step_cnt_t'(STEP_H);
    localparam player_pkg::step_cnt_t STEP_V_C = player_pkg::step_cnt_t'(STEP_V);

    player_pkg::step_cnt_t    cnt_h;
    player_pkg::step_cnt_t    cnt_v;
    map_geometry_pkg::coord_t disp_h_q;
    map_geometry_pkg::coord_t disp_v_q;
    logic                     h_move;
    logic                     v_move;

    assign h_move = (pl.state == player_pkg::RIGHT) || (pl.state == player_pkg::LEFT);
    assign v_move = h_move || (pl.state == player_pkg::UP);  // jumps also run while walking

    assign pl.disp_h = disp_h_q;
    assign pl.disp_v = disp_v_q;

    // horizontal pacing, one step per STEP_H+1 cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_h    <= '0;
            disp_h_q <= '0;
        end else if (pl.state == player_pkg::STILL) begin
            cnt_h <= '0;  // restart pacing on next walk
        end else if (h_move) begin
            if (cnt_h < STEP_H_C) begin
                cnt_h <= cnt_h + 1'b1;
            end else begin
                cnt_h <= '0;
                if (pl.state == player_pkg::RIGHT) begin
                    if (disp_h_q <= player_pkg::MAX_DISP_H && !blocked)
                        disp_h_q <= disp_h_q + 1'b1;
                end else if (disp_h_q > '0) begin  // left, stop at the spawn column
                    disp_h_q <= disp_h_q - 1'b1;
                end
            end
        end
    end

    // vertical pacing, jump phase picks direction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_v    <= '0;
            disp_v_q <= '0;
        end else if (v_move) begin
            case (pl.jump)
                player_pkg::NONE: cnt_v <= '0;
                player_pkg::RISE,
                player_pkg::FALL: begin
                    if (cnt_v < STEP_V_C) begin
                        cnt_v <= cnt_v + 1'b1;
                    end else begin
                        cnt_v <= '0;
                        if (pl.jump == player_pkg::RISE)
                            disp_v_q <= disp_v_q + 1'b1;
                        else if (disp_v_q > '0)
                            disp_v_q <= disp_v_q - 1'b1;  // floor is the lower bound
                    end
                end
                default: cnt_v <= cnt_v;  // unused phase code, hold
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/player_pkg.sv ====
`default_nettype none

package player_pkg;

    typedef enum logic [3:0] {
        STILL = 4'd6,
        RIGHT = 4'd7,
        LEFT  = 4'd8,
        UP    = 4'd9
    } player_state_e;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        RISE = 2'd1,
        FALL = 2'd2
    } jump_e;

    // sprite pose, up splits on the jump phase
    typedef enum logic [2:0] {POSE_STILL, POSE_RIGHT, POSE_LEFT, POSE_UP_RISE, POSE_UP} pose_e;

    typedef logic [24:0] step_cnt_t;  // room for the full-speed step periods

    localparam map_geometry_pkg::coord_t MAX_DISP_H = 10'd282; // right-move cap
    localparam map_geometry_pkg::coord_t FOOT_V     = 10'd230; // foot line at disp_v 0
    localparam int STEP_H_DEFAULT = 1_500_000;
    localparam int STEP_V_DEFAULT = 2_000_000;

    // box left edge and width at disp_h 0, top and bottom at disp_v 0
    typedef struct packed {
        map_geometry_pkg::coord_t left;
        map_geometry_pkg::coord_t width;
        map_geometry_pkg::coord_t top;
        map_geometry_pkg::coord_t bot;
        map_geometry_pkg::coord_t sheet_h;
        map_geometry_pkg::coord_t sheet_v;
    } sprite_box_t;

    localparam sprite_box_t SPRITE_BOX [0:4] = '{
        POSE_STILL:   '{10'd13, 10'd15, 10'd200, FOOT_V,         10'd53, 10'd0},
        POSE_RIGHT:   '{10'd8,  10'd14, 10'd200, FOOT_V,         10'd71, 10'd0},
        POSE_LEFT:    '{10'd8,  10'd14, 10'd200, FOOT_V,         10'd86, 10'd0},
        POSE_UP_RISE: '{10'd10, 10'd15, 10'd199, FOOT_V - 10'd3, 10'd53, 10'd30},
        POSE_UP:      '{10'd10, 10'd15, 10'd200, FOOT_V,         10'd53, 10'd0}
    };

endpackage

`default_nettype wire

// ==== hw/sprite_addr.sv ====
`timescale 1ns/1ns
`default_nettype none

module sprite_addr (
    input  map_geometry_pkg::coord_t      vga_h,
    input  map_geometry_pkg::coord_t      vga_v,
    player_if.observer                    pl,
    input  logic                          t_hit,
    input  map_geometry_pkg::sheet_addr_t t_addr,
    output map_geometry_pkg::sheet_addr_t addr
);

    map_geometry_pkg::coord_t      h;
    map_geometry_pkg::coord_t      v;
    player_pkg::sprite_box_t       box;
    logic                          pose_ok;  // low for state codes outside the enum
    logic [10:0]                   h_lo;
    logic [10:0]                   h_hi;
    logic [10:0]                   v_abs;    // v shifted back to disp_v 0
    logic [10:0]                   col;
    logic [10:0]                   row;
    logic                          in_box;
    map_geometry_pkg::sheet_addr_t s_addr;

    assign h = vga_h >> 1;
    assign v = vga_v >> 1;

    // pose lookup
    always_comb begin
        box     = player_pkg::SPRITE_BOX[player_pkg::POSE_STILL];
        pose_ok = 1'b1;
        case (pl.state)
            player_pkg::STILL: box = player_pkg::SPRITE_BOX[player_pkg::POSE_STILL];
            player_pkg::RIGHT: box = player_pkg::SPRITE_BOX[player_pkg::POSE_RIGHT];
            player_pkg::LEFT:  box = player_pkg::SPRITE_BOX[player_pkg::POSE_LEFT];
            player_pkg::UP: begin
                if (pl.jump == player_pkg::RISE)
                    box = player_pkg::SPRITE_BOX[player_pkg::POSE_UP_RISE];
                else
                    box = player_pkg::SPRITE_BOX[player_pkg::POSE_UP];
            end
            default: pose_ok = 1'b0;
        endcase
    end

    // 11 bits so the edges never wrap
    assign h_lo  = 11'(pl.disp_h) + 11'(box.left);
    assign h_hi  = h_lo + 11'(box.width);
    assign v_abs = 11'(v) + 11'(pl.disp_v);

    assign in_box = pose_ok && (11'(h) >= h_lo) && (11'(h) < h_hi)
                 && (v_abs >= 11'(box.top)) && (v_abs < 11'(box.bot));

    assign col    = 11'(h) - h_lo + 11'(box.sheet_h);
    assign row    = v_abs - 11'(box.top) + 11'(box.sheet_v);
    assign s_addr = map_geometry_pkg::sheet_addr_t'(col)
                  + map_geometry_pkg::sheet_addr_t'(row)
                  * map_geometry_pkg::sheet_addr_t'(map_geometry_pkg::MAP_W);

    // terrain over player over background
    assign addr = t_hit  ? t_addr :
                  in_box ? s_addr : map_geometry_pkg::BG_ADDR;

endmodule

`default_nettype wire

// ==== hw/terrain_addr.sv ====
`timescale 1ns/1ns
`default_nettype none

module terrain_addr (
    input  map_geometry_pkg::coord_t      vga_h,
    input  map_geometry_pkg::coord_t      vga_v,
    output logic                          hit,
    output map_geometry_pkg::sheet_addr_t t_addr
);

    map_geometry_pkg::coord_t h;
    map_geometry_pkg::coord_t v;
    logic                     on_map;

    // true when the map pixel falls inside the rectangle
    function automatic logic in_rect(
        input map_geometry_pkg::coord_t        ph,
        input map_geometry_pkg::coord_t        pv,
        input map_geometry_pkg::terrain_rect_t r
    );
        in_rect = (ph >= r.org_h) && (ph < r.org_h + r.width)
               && (pv >= r.org_v) && (pv < r.org_v + r.height);
    endfunction

    // sheet address for a pixel inside the rectangle
    function automatic map_geometry_pkg::sheet_addr_t rect_addr(
        input map_geometry_pkg::coord_t        ph,
        input map_geometry_pkg::coord_t        pv,
        input map_geometry_pkg::terrain_rect_t r
    );
        map_geometry_pkg::coord_t col;
        map_geometry_pkg::coord_t row;
        if (r.solid) begin
            col = r.sheet_h;  // one texel for the whole piece
            row = r.sheet_v;
        end else begin
            col = ph - r.org_h + r.sheet_h;
            row = pv - r.org_v + r.sheet_v;
        end
        rect_addr = map_geometry_pkg::sheet_addr_t'(col)
                  + map_geometry_pkg::sheet_addr_t'(row)
                  * map_geometry_pkg::sheet_addr_t'(map_geometry_pkg::MAP_W);
    endfunction

    assign h      = vga_h >> 1;  // 640x480 scan to 320x240 map
    assign v      = vga_v >> 1;
    assign on_map = (h < map_geometry_pkg::MAP_W) && (v < map_geometry_pkg::MAP_H);

    // priority search, first matching entry wins
    always_comb begin
        hit    = 1'b0;
        t_addr = '0;
        for (int i = 0; i < map_geometry_pkg::TERRAIN_COUNT; i++) begin
            if (on_map && !hit && in_rect(h, v, map_geometry_pkg::TERRAIN_TABLE[i])) begin
                hit    = 1'b1;
                t_addr = rect_addr(h, v, map_geometry_pkg::TERRAIN_TABLE[i]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module game_map_tb -f files.f > build.log 2>&1 &&
    ./obj_dir/Vgame_map_tb +verilator+error+limit+100 > sim.log 2>&1 ||
    echo "build or simulation exited with an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 ||
    { echo "simulation failed"; exit 1; }

// ==== testbench/game_map_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

// led must track the contact flags one clock later
module game_map_chk (
    input logic                      clk,
    input logic                      rst,
    input player_pkg::player_state_e player_state,
    input logic                      p1_collision,
    input logic                      p1_land,
    input logic                      should_down,
    input logic [15:0]               led
);

    int fail_count = 0;  // summed into the closing line of the testbench

    // quiet cycle gives the idle pattern
    idle_led: assert property (@(posedge clk) disable iff (rst)
        (!p1_collision && !p1_land && !should_down) |=> (led == 16'h000F))
        else begin
            fail_count = fail_count + 1;
            $error("led is not 0x000F after a cycle with no contact flag");
        end

    // collision while standing still lights everything
    still_hit_led: assert property (@(posedge clk) disable iff (rst)
        (p1_collision && player_state == player_pkg::STILL) |=> (led == 16'hFFFF))
        else begin
            fail_count = fail_count + 1;
            $error("led is not 0xFFFF after a collision while still");
        end

    land_led: assert property (@(posedge clk) disable iff (rst)
        (p1_land && !p1_collision) |=> (led == 16'h3FFF))  // landing without a hit
        else begin
            fail_count = fail_count + 1;
            $error("led is not 0x3FFF after a landing");
        end

endmodule

bind game_map_top game_map_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .player_state (player_state),
    .p1_collision (p1_collision),
    .p1_land      (p1_land),
    .should_down  (should_down),
    .led          (led)
);

`default_nettype wire

// ==== testbench/game_map_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_map_tb;

    localparam int STEP_H     = 3;     // 4 cycles per horizontal step
    localparam int STEP_V     = 4;     // 5 cycles per vertical step
    localparam int WAIT_LIMIT = 2000;  // longest wait is about 1000 cycles

    logic                          clk;
    logic                          rst;
    map_geometry_pkg::coord_t      vga_h;
    map_geometry_pkg::coord_t      vga_v;
    player_pkg::player_state_e     player_state;
    player_pkg::jump_e             player_jump;
    map_geometry_pkg::sheet_addr_t addr;
    logic [15:0]                   led;
    logic                          p1_collision;
    logic                          p1_land;
    logic                          should_down;

    int          err_cnt;
    int          timeout_cnt;
    logic [31:0] lcg_state;

    game_map_top #(
        .STEP_H (STEP_H),
        .STEP_V (STEP_V)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .vga_h        (vga_h),
        .vga_v        (vga_v),
        .player_state (player_state),
        .player_jump  (player_jump),
        .addr         (addr),
        .led          (led),
        .p1_collision (p1_collision),
        .p1_land      (p1_land),
        .should_down  (should_down)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // value in lo .. lo+span-1
    function automatic int pick(input int lo, input int span);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        pick = lo + int'((lcg_state >> 8) % 32'(span));  // low lcg bits repeat too fast
    endfunction

    // sheet texel for map pixel (h, v) of an image with its corner at (org_h, org_v)
    function automatic map_geometry_pkg::sheet_addr_t texel(
        input int h, input int v, input int org_h, input int org_v,
        input int sheet_h, input int sheet_v
    );
        texel = map_geometry_pkg::sheet_addr_t'((h - org_h + sheet_h)
                                                + (v - org_v + sheet_v) * 320);
    endfunction

    task automatic check_addr(input map_geometry_pkg::sheet_addr_t exp, input string what);
        if (addr !== exp) begin
            $display("[FAIL] %0t ns: %s addr %0d, expected %0d", $time, what, addr, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_led(input logic [15:0] exp, input string what);
        if (led !== exp) begin
            $display("[FAIL] %0t ns: %s led %h, expected %h", $time, what, led, exp);
            err_cnt++;
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("[FAIL] %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // caller sits on a falling edge
    task automatic apply_reset();
        rst          = 1'b1;
        player_state = player_pkg::STILL;
        player_jump  = player_pkg::NONE;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    // either scan pixel of the 2x2 group maps to (h, v)
    task automatic set_scan(input int h, input int v);
        @(negedge clk);
        vga_h = map_geometry_pkg::coord_t'(2 * h + pick(0, 2));
        vga_v = map_geometry_pkg::coord_t'(2 * v + pick(0, 2));
        #2;  // mid low phase, address settled
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_led(16'h000F, "after reset");
        check_flag(p1_collision, 1'b0, "p1_collision after reset");
        check_flag(p1_land, 1'b0, "p1_land after reset");
        check_flag(should_down, 1'b0, "should_down after reset");
    endtask

    task automatic test_terrain();
        int h;
        int v;
        int n;
        for (n = 0; n < 8; n++) begin
            h = pick(0, 320);   // ceiling band
            v = pick(0, 10);
            set_scan(h, v);
            check_addr(texel(h, v, 0, 0, 0, 220), "ceiling");
            h = pick(0, 10);    // left boundary strip
            v = pick(10, 220);
            set_scan(h, v);
            check_addr(texel(h, v, 0, 10, 305, 10), "left bound");
            h = pick(275, 35);  // wall 7 block
            v = pick(210, 20);
            set_scan(h, v);
            check_addr(texel(h, v, 275, 210, 305, 212), "wall 7");
            h = pick(160, 20);  // red river is one texel
            v = pick(230, 6);
            set_scan(h, v);
            check_addr(17'd19521, "red river");
        end
    endtask

    task automatic test_sprite_still();
        set_scan(20, 210);  // inside the standing box at the origin
        check_addr(texel(20, 210, 13, 200, 53, 0), "still sprite");
        set_scan(100, 150);
        check_addr(17'd12900, "open space");
    endtask

    task automatic test_right_motion();
        int cycles;
        @(negedge clk);
        player_state = player_pkg::RIGHT;
        player_jump  = player_pkg::NONE;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!p1_collision && cycles < WAIT_LIMIT);
        if (!p1_collision) begin
            $display("timeout: p1_collision did not rise while walking right");
            timeout_cnt++;
        end else begin
            check_cycles(cycles, 247 * (STEP_H + 1), "walk to wall 7");
        end
        repeat (3 * (STEP_H + 1)) @(negedge clk);  // three more step periods, still blocked
        check_flag(p1_collision, 1'b1, "p1_collision held at wall 7");
        check_led(16'hFFFF, "blocked at wall 7");
        set_scan(260, 210);  // right box spans 255..268 at disp_h 247
        check_addr(texel(260, 210, 247 + 8, 200, 71, 0), "right sprite at wall 7");
        set_scan(269, 210);
        check_addr(17'd12900, "just past the right sprite");
    endtask

    task automatic test_rise_fall();
        int cycles;
        @(negedge clk);
        apply_reset();
        player_state = player_pkg::UP;
        player_jump  = player_pkg::RISE;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!p1_collision && cycles < WAIT_LIMIT);
        if (!p1_collision) begin
            $display("timeout: p1_collision did not rise under the ceiling of wall 1");
            timeout_cnt++;
        end else begin
            check_cycles(cycles, 9 * (STEP_V + 1), "rise to disp_v 9");
        end
        player_state = player_pkg::STILL;  // head stays on wall 1, disp_v held at 9
        repeat (2) @(negedge clk);
        check_flag(p1_collision, 1'b1, "p1_collision while still under wall 1");
        check_led(16'hFFFF, "still under wall 1");
        player_state = player_pkg::UP;
        player_jump  = player_pkg::FALL;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!p1_land && cycles < WAIT_LIMIT);
        if (!p1_land) begin
            $display("timeout: p1_land did not rise while falling to the floor");
            timeout_cnt++;
        end else begin
            check_cycles(cycles, 9 * (STEP_V + 1), "fall back to the floor");
        end
        @(negedge clk);
        check_led(16'h3FFF, "landed on the floor");
    endtask

    task automatic test_left_hold();
        int n;
        @(negedge clk);
        apply_reset();
        player_state = player_pkg::LEFT;
        player_jump  = player_pkg::NONE;
        set_scan(10, 210);  // left box spans 8..21 at disp_h 0
        check_addr(texel(10, 210, 8, 200, 86, 0), "left sprite at spawn");
        for (n = 0; n < 5 * (STEP_H + 1); n++) begin
            @(negedge clk);
            check_flag(p1_collision, 1'b0, "p1_collision walking left at 0");
            check_flag(p1_land, 1'b0, "p1_land walking left at 0");
            check_flag(should_down, 1'b0, "should_down walking left at 0");
        end
        check_addr(texel(10, 210, 8, 200, 86, 0), "left sprite after five steps");
    endtask

    // left fall rule, reached by rising at the spawn column to disp_v 19
    task automatic test_edge_fall();
        int cycles;
        player_state = player_pkg::LEFT;
        player_jump  = player_pkg::RISE;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!should_down && cycles < WAIT_LIMIT);
        if (!should_down) begin
            $display("timeout: should_down did not rise while rising on the left");
            timeout_cnt++;
        end else begin
            check_cycles(cycles, 19 * (STEP_V + 1), "rise to disp_v 19");
        end
        @(negedge clk);
        check_flag(should_down, 1'b1, "should_down at disp_v 19");
        check_led(16'h0FFF, "off the ledge");
    endtask

    initial begin
        rst          = 1'b1;
        vga_h        = '0;
        vga_v        = '0;
        player_state = player_pkg::STILL;
        player_jump  = player_pkg::NONE;
        err_cnt      = 0;
        timeout_cnt  = 0;
        lcg_state    = 32'd78283;
        apply_reset();
        test_reset_state();
        test_terrain();
        test_sprite_still();
        test_right_motion();
        test_rise_fall();
        test_left_hold();
        test_edge_fall();
        @(negedge clk);
        $display("errors: %0d wrong values, %0d timeouts, %0d assertion failures",
                 err_cnt, timeout_cnt, UUT.u_chk.fail_count);
        if (err_cnt == 0 && timeout_cnt == 0 && UUT.u_chk.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
